// ==== sim.f ====
common/cpuPkg.sv
fetch/ProgramCounter.sv
fetch/InstructionMemory.sv
decode/ConditionCheck.sv
decode/InstructionDecoder.sv
hdl/FrontEnd.sv
dv/ClockGen.sv
dv/FrontEndChecker.sv
dv/FrontEnd_sva.sv
dv/FrontEndTb.sv

// ==== Makefile ====
TOOL      := verilator
FLAGS     := --timing --assert
TOP       := FrontEndTb
FILELIST  := sim.f
BUILD     := obj_dir
LOG       := sim.log
PASS_TEXT := Finished with no errors

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== dv/FrontEndTb.sv ====
`timescale 1ns/1ps

module FrontEndTb import cpuPkg::*; ();

    // one stimulus row of cycles, stall level, nzcv flags and a random-flags bit
    typedef struct packed {
        logic [7:0] cycles;
        logic       stall;
        flags_t     flags;
        logic       randFlags;
    } stimRow_t;

    localparam int NUM_ROWS = 8;

    logic        clk;
    logic        rst;
    logic        stall;
    flags_t      flags;
    decoded_t    decoded;
    logic        valid;

    stimRow_t    stimRows [NUM_ROWS];
    integer      seed;
    logic [31:0] randWord;
    int          waitCount;
    int          timeouts;
    int          missing;
    int          r;
    int          c;

    ClockGen #(
        .halfPeriod  (2),
        .resetCycles (4)
    ) ClockGen_inst (
        .clk (clk),
        .rst (rst)
    );

    FrontEnd #(
        .testProgram (PROG_LOOP)
    ) FrontEnd_inst (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .flags   (flags),
        .decoded (decoded),
        .valid   (valid)
    );

    FrontEndChecker scoreboard (
        .clk     (clk),
        .rst     (rst),
        .stall   (stall),
        .flags   (flags),
        .decoded (decoded),
        .valid   (valid)
    );

    initial begin
        stall    <= 1'b0;
        flags    <= '0;
        seed     = 9;
        timeouts = 0;
        missing  = 0;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // stimulus table with flags as n z c v
        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // C clear so HI falls through to word 9
        stimRows[0] = {8'd24, 1'b0, 4'b0000, 1'b0};
        stimRows[1] = {8'd3,  1'b1, 4'b0000, 1'b0};
        // C set, Z clear, so HI exits the loop
        stimRows[2] = {8'd16, 1'b0, 4'b0010, 1'b0};
        stimRows[3] = {8'd48, 1'b0, 4'b0000, 1'b1};
        stimRows[4] = {8'd5,  1'b1, 4'b0010, 1'b0};
        // Z and C both set so HI fails
        stimRows[5] = {8'd20, 1'b0, 4'b0110, 1'b0};
        stimRows[6] = {8'd40, 1'b0, 4'b0000, 1'b1};
        stimRows[7] = {8'd2,  1'b1, 4'b0000, 1'b0};

        waitCount = 0;
        while (rst !== 1'b0 && waitCount < 50) begin
            @(posedge clk);
            waitCount++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("reset was never released");
        end

        // first fetch shows up one edge after reset drops
        waitCount = 0;
        while (timeouts == 0 && valid !== 1'b1 && waitCount < 10) begin
            @(posedge clk);
            waitCount++;
        end
        if (timeouts == 0 && valid !== 1'b1) begin
            timeouts++;
            $display("valid never rose after reset");
        end

        if (timeouts == 0) begin
            for (r = 0; r < NUM_ROWS; r++) begin
                for (c = 0; c < int'(stimRows[r].cycles); c++) begin
                    @(posedge clk);
                    stall <= stimRows[r].stall;
                    if (stimRows[r].randFlags) begin
                        randWord = $random(seed);
                        flags <= randWord[3:0];
                    end else begin
                        flags <= stimRows[r].flags;
                    end
                end
                $display("row %0d: %0d cycles, stall %0b, checks %0d, errors %0d",
                    r, stimRows[r].cycles, stimRows[r].stall,
                    scoreboard.checkCount, scoreboard.errorCount);
            end
            @(posedge clk);
            stall <= 1'b0;
            repeat (2) @(posedge clk);
            // let the checker finish the last edge
            @(negedge clk);
        end

        if (scoreboard.hiTaken == 0 || scoreboard.hiFallThrough == 0) begin
            missing++;
            $display("the HI branch did not see both outcomes");
        end

        $display("checks %0d, errors %0d, assertion failures %0d, timeouts %0d, %s %0d, %s %0d",
            scoreboard.checkCount, scoreboard.errorCount,
            FrontEnd_inst.FrontEndSva_inst.failCount, timeouts,
            "HI taken", scoreboard.hiTaken, "HI not taken", scoreboard.hiFallThrough);
        if (scoreboard.errorCount == 0 && timeouts == 0 && missing == 0
                && FrontEnd_inst.FrontEndSva_inst.failCount == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== dv/FrontEnd_sva.sv ====
`timescale 1ns/1ps

module FrontEndSva (
    input logic        clk,
    input logic        rst,
    input logic        stall,
    input logic        valid,
    input logic [31:0] pc
);

    int failCount = 0;

    // valid clears on the edge that sees reset
    validLowInReset: assert property (@(posedge clk) rst |=> !valid)
        else begin
            failCount++;
            $error("valid high after a reset edge");
        end

    pcHoldsOnStall: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(pc))
        else begin
            failCount++;
            $error("pc moved while stalled");
        end

    pcWordAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else begin
            failCount++;
            $error("pc not word aligned");
        end

endmodule

bind FrontEnd FrontEndSva FrontEndSva_inst (
    .clk   (clk),
    .rst   (rst),
    .stall (stall),
    .valid (valid),
    .pc    (pc)
);

// ==== dv/FrontEndChecker.sv ====
`timescale 1ns/1ps

module FrontEndChecker import cpuPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     stall,
    input flags_t   flags,
    input decoded_t decoded,
    input logic     valid
);

    logic [31:0] prog [14];
    logic [31:0] modelPc;
    logic [31:0] word;
    logic        havePredict;
    logic        isMul;
    decoded_t    expected;
    int          idx;
    int          offset;
    int          errorCount = 0;
    int          checkCount = 0;
    int          hiTaken = 0;
    int          hiFallThrough = 0;

    // loop program that squares and compares until HI
    initial begin
        prog[0]  = 32'hE59F11FC;
        prog[1]  = 32'hE59F21F4;
        prog[2]  = 32'hE59F31F8;
        prog[3]  = 32'hE5914000;
        prog[4]  = 32'hE5824000;
        prog[5]  = 32'hE3A09000;
        prog[6]  = 32'hE00B0999;
        prog[7]  = 32'hE15B0004;
        prog[8]  = 32'h8A000001;
        prog[9]  = 32'hE2899001;
        prog[10] = 32'hEAFFFFFA;
        prog[11] = 32'hE2499001;
        prog[12] = 32'hE5839000;
        prog[13] = 32'hEAFFFFF4;
    end

    // odd condition codes negate the even ones, so NV comes out as never
    function automatic logic condHolds(input logic [3:0] cond, input flags_t f);
        logic base;
        case (cond[3:1])
            3'd0:    base = f.z;
            3'd1:    base = f.c;
            3'd2:    base = f.n;
            3'd3:    base = f.v;
            3'd4:    base = f.c & ~f.z;
            3'd5:    base = (f.n == f.v);
            3'd6:    base = ~f.z & (f.n == f.v);
            default: base = 1'b1;
        endcase
        return cond[0] ? ~base : base;
    endfunction

    function automatic instrClass_e classOf(input logic [31:0] w);
        if (w[27:22] == 6'd0 && w[7:4] == 4'b1001) begin
            return multiply;
        end
        case (w[27:25])
            3'b000:  return dataProc;
            3'b001:  return dataProcImm;
            3'b011:  return w[4] ? undefined : loadStore;
            3'b101:  return branch;
            3'b110:  return coproc;
            3'b111:  return coproc;
            default: return loadStore;
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        if (exp !== act) begin
            errorCount++;
            $display("[ERROR] %s expected 0x%0h, got 0x%0h (pc 0x%0h)",
                name, exp, act, expected.pc);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare last prediction, then fetch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin
        if (rst) begin
            modelPc     = 32'd0;
            havePredict = 1'b0;
        end else begin
            checkCount++;
            if (havePredict && valid !== 1'b1) begin
                errorCount++;
                $display("valid dropped after the first fetch");
            end else if (!havePredict && valid !== 1'b0) begin
                errorCount++;
                $display("valid is high before any word was fetched");
            end
            // a held register still has to match the last prediction
            if (havePredict) begin
                compare("decoded.pc", expected.pc, decoded.pc);
                compare("decoded.cond", 32'(expected.cond), 32'(decoded.cond));
                compare("decoded.cls", 32'(expected.cls), 32'(decoded.cls));
                compare("decoded.op", 32'(expected.op), 32'(decoded.op));
                compare("decoded.setFlags", 32'(expected.setFlags), 32'(decoded.setFlags));
                compare("decoded.rd", 32'(expected.rd), 32'(decoded.rd));
                compare("decoded.rn", 32'(expected.rn), 32'(decoded.rn));
                compare("decoded.rm", 32'(expected.rm), 32'(decoded.rm));
                compare("decoded.imm12", 32'(expected.imm12), 32'(decoded.imm12));
                compare("decoded.condPass", 32'(expected.condPass), 32'(decoded.condPass));
            end
            if (!stall) begin
                idx = int'(modelPc[31:2]);
                if (idx >= 14) begin
                    errorCount++;
                    $display("model pc 0x%0h ran past the loop program", modelPc);
                    idx = 0;
                end
                word  = prog[idx];
                isMul = (word[27:22] == 6'd0) && (word[7:4] == 4'b1001);
                expected          = '0;
                expected.pc       = modelPc;
                expected.cond     = word[31:28];
                expected.cls      = classOf(word);
                expected.op       = aluOp_e'(word[24:21]);
                expected.setFlags = word[20];
                expected.rd       = isMul ? word[19:16] : word[15:12];
                expected.rn       = isMul ? word[15:12] : word[19:16];
                expected.rm       = word[3:0];
                expected.imm12    = word[11:0];
                expected.condPass = condHolds(word[31:28], flags);
                if (idx == 8 && expected.condPass) begin
                    hiTaken++;
                end else if (idx == 8) begin
                    hiFallThrough++;
                end
                if (expected.cls == branch && expected.condPass) begin
                    // signed word offset from the fetch address plus 8
                    offset  = int'($signed(word[23:0]));
                    modelPc = modelPc + 32'd8 + 32'(offset * 4);
                end else begin
                    modelPc = modelPc + 32'd4;
                end
                havePredict = 1'b1;
            end
        end
    end

endmodule

// ==== dv/ClockGen.sv ====
`timescale 1ns/1ps

module ClockGen #(
    parameter int halfPeriod  = 2,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // reset spans the first few rising edges
    initial begin
        rst <= 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== hdl/FrontEnd.sv ====
`timescale 1ns/1ps

module FrontEnd import cpuPkg::*; #(
    parameter int testProgram = PROG_MIXED
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  flags_t   flags,
    output decoded_t decoded,
    output logic     valid
);

    logic [31:0] pc;
    logic [31:0] instr;
    logic        condPass;
    logic        branchTaken;
    logic [31:0] branchTarget;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ProgramCounter ProgramCounter_inst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .pc           (pc)
    );

    InstructionMemory #(
        .testProgram (testProgram)
    ) InstructionMemory_inst (
        .pc    (pc),
        .instr (instr)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    ConditionCheck ConditionCheck_inst (
        .cond     (instr[31:28]),
        .flags    (flags),
        .condPass (condPass)
    );

    // taken branches loop straight back into the PC
    InstructionDecoder InstructionDecoder_inst (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .pc           (pc),
        .instr        (instr),
        .condPass     (condPass),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .decoded      (decoded),
        .valid        (valid)
    );

endmodule

// ==== decode/InstructionDecoder.sv ====
`timescale 1ns/1ps

module InstructionDecoder import cpuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic        condPass,
    output logic        branchTaken,
    output logic [31:0] branchTarget,
    output decoded_t    decoded,
    output logic        valid
);

    instrClass_e cls;
    decoded_t    decNext;
    logic        isMultiply;
    logic [31:0] branchOffset;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // classification
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // MUL/MLA share the 000 space, told apart by 1001 in bits 7:4
    assign isMultiply = (instr[27:22] == 6'b000000) && (instr[7:4] == 4'b1001);

    always_comb begin
        if (isMultiply) begin
            cls = multiply;
        end else begin
            case (instr[27:25])
                3'b000:  cls = dataProc;
                3'b001:  cls = dataProcImm;
                3'b010:  cls = loadStore;
                // register-offset form with bit 4 set is architecturally undefined
                3'b011:  cls = instr[4] ? undefined : loadStore;
                3'b100:  cls = loadStore;
                3'b101:  cls = branch;
                default: cls = coproc;
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // branch resolution
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 24-bit word offset, relative to pc + 8
    assign branchOffset = {{6{instr[23]}}, instr[23:0], 2'b00};
    assign branchTarget = pc + 32'd8 + branchOffset;
    assign branchTaken  = (cls == branch) && condPass;

    // field extraction
    always_comb begin
        decNext.pc       = pc;
        decNext.cond     = instr[31:28];
        decNext.cls      = cls;
        decNext.op       = aluOp_e'(instr[24:21]);
        decNext.setFlags = instr[20];
        decNext.rm       = instr[3:0];
        decNext.imm12    = instr[11:0];
        decNext.condPass = condPass;
        if (isMultiply) begin
            // multiply swaps rd and rn positions
            decNext.rd = instr[19:16];
            decNext.rn = instr[15:12];
        end else begin
            decNext.rd = instr[15:12];
            decNext.rn = instr[19:16];
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            decoded <= decNext;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (!stall) begin
            valid <= 1'b1;
        end
    end

endmodule

// ==== decode/ConditionCheck.sv ====
`timescale 1ns/1ps

module ConditionCheck import cpuPkg::*; (
    input  logic [3:0] cond,
    input  flags_t     flags,
    output logic       condPass
);

    logic nEqualsV;

    assign nEqualsV = (flags.n == flags.v);

    always_comb begin
        case (cond)
            4'h0: condPass = flags.z;                   // EQ
            4'h1: condPass = !flags.z;                  // NE
            4'h2: condPass = flags.c;                   // CS/HS
            4'h3: condPass = !flags.c;                  // CC/LO
            4'h4: condPass = flags.n;                   // MI
            4'h5: condPass = !flags.n;                  // PL
            4'h6: condPass = flags.v;                   // VS
            4'h7: condPass = !flags.v;                  // VC
            // unsigned higher / lower-or-same
            4'h8: condPass = flags.c && !flags.z;
            4'h9: condPass = !flags.c || flags.z;
            // signed compares
            4'hA: condPass = nEqualsV;                  // GE
            4'hB: condPass = !nEqualsV;                 // LT
            4'hC: condPass = !flags.z && nEqualsV;      // GT
            4'hD: condPass = flags.z || !nEqualsV;      // LE
            4'hE: condPass = 1'b1;                      // AL
            // NV never executes
            default: condPass = 1'b0;
        endcase
    end

endmodule

// ==== fetch/InstructionMemory.sv ====
`timescale 1ns/1ps

module InstructionMemory import cpuPkg::*; #(
    parameter int testProgram = PROG_MIXED
) (
    input  logic [31:0] pc,
    output logic [31:0] instr
);

    logic [31:0] rom [ROM_WORDS];
    logic        inRange;
    integer      i;

    initial begin
        for (i = 0; i < ROM_WORDS; i = i + 1) begin
            rom[i] = 32'h0;
        end
        case (testProgram)
            PROG_MIXED: begin
                // literal loads
                rom[0]  = 32'hE59F1204;
                rom[1]  = 32'hE59F9204;
                rom[2]  = 32'hE59F8204;
                rom[3]  = 32'hE59F31EC;
                rom[4]  = 32'hE59F41EC;
                rom[5]  = 32'hE59FC1EC;
                // arithmetic, stores and logic ops
                rom[6]  = 32'hE0815003;
                rom[7]  = 32'hE5835004;
                rom[8]  = 32'hE0815005;
                rom[9]  = 32'hE5845000;
                rom[10] = 32'hE5934004;
                rom[11] = 32'hE0456003;
                rom[12] = 32'hE0066004;
                rom[13] = 32'hE1816004;
                rom[14] = 32'hE0646006;
                rom[15] = 32'hE0886008;
                rom[16] = 32'hE0C56004;
                rom[17] = 32'hE0E46005;
                // compares, all four flavors
                rom[18] = 32'hE1160001;
                rom[19] = 32'hE1360001;
                rom[20] = 32'hE1560003;
                rom[21] = 32'hE1760003;
                rom[22] = 32'hE0266001;
                rom[23] = 32'hE1E06001;
                rom[24] = 32'hE1C66008;
                rom[25] = 32'hE3A06009;
                // multiply, then odd encodings
                rom[26] = 32'hE0070196;
                rom[27] = 32'hE59F31D4;
                rom[28] = 32'hE2933000;
                rom[29] = 32'h000A0791;
                rom[30] = 32'hE7FC0CFA;
                rom[31] = 32'h07FB06FC;
            end
            PROG_LOOP: begin
                rom[0]  = 32'hE59F11FC;
                rom[1]  = 32'hE59F21F4;
                rom[2]  = 32'hE59F31F8;
                rom[3]  = 32'hE5914000;
                rom[4]  = 32'hE5824000;
                rom[5]  = 32'hE3A09000;
                // loop body: square, compare, exit on HI
                rom[6]  = 32'hE00B0999;
                rom[7]  = 32'hE15B0004;
                rom[8]  = 32'h8A000001;
                rom[9]  = 32'hE2899001;
                rom[10] = 32'hEAFFFFFA;
                rom[11] = 32'hE2499001;
                rom[12] = 32'hE5839000;
                rom[13] = 32'hEAFFFFF4;
            end
            PROG_VFP: begin
                rom[0]  = 32'hE59F1208;
                rom[1]  = 32'hEE312A01;
                // spin here forever
                rom[2]  = 32'hEAFFFFFE;
            end
            default: begin
                // leave the table empty
                rom[0]  = 32'h0;
            end
        endcase
    end

    // anything past the table reads as zero
    assign inRange = (pc[31:9] == '0);
    assign instr   = inRange ? rom[pc[8:2]] : 32'h0;

endmodule

// ==== fetch/ProgramCounter.sv ====
`timescale 1ns/1ps

module ProgramCounter (
    input  logic        clk,
    input  logic        rst,
    input  logic        stall,
    input  logic        branchTaken,
    input  logic [31:0] branchTarget,
    output logic [31:0] pc
);

    logic [31:0] pcReg;
    logic [31:0] pcNext;

    // priority: reset, stall, branch, sequential
    always_comb begin
        if (stall) begin
            pcNext = pcReg;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pcReg + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= 32'd0;
        end else begin
            pcReg <= pcNext;
        end
    end

    assign pc = pcReg;

endmodule

// ==== common/cpuPkg.sv ====
package cpuPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction classes and opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // coarse class, from bits 27:25 plus the multiply pattern
    typedef enum logic [2:0] {
        dataProc    = 3'd0,
        dataProcImm = 3'd1,
        multiply    = 3'd2,
        loadStore   = 3'd3,
        branch      = 3'd4,
        coproc      = 3'd5,
        undefined   = 3'd6
    } instrClass_e;

    // data-processing opcode, bits 24:21
    typedef enum logic [3:0] {
        opAnd = 4'h0,
        opEor = 4'h1,
        opSub = 4'h2,
        opRsb = 4'h3,
        opAdd = 4'h4,
        opAdc = 4'h5,
        opSbc = 4'h6,
        opRsc = 4'h7,
        opTst = 4'h8,
        opTeq = 4'h9,
        opCmp = 4'hA,
        opCmn = 4'hB,
        opOrr = 4'hC,
        opMov = 4'hD,
        opBic = 4'hE,
        opMvn = 4'hF
    } aluOp_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [3:0]  cond;
        instrClass_e cls;
        aluOp_e      op;
        logic        setFlags;
        logic [3:0]  rn;
        logic [3:0]  rd;
        logic [3:0]  rm;
        logic [11:0] imm12;
        // reported downstream as-is
        logic        condPass;
    } decoded_t;

    localparam int ROM_WORDS = 128;

    // program selector values
    localparam int PROG_MIXED = 0;
    localparam int PROG_LOOP  = 1;
    localparam int PROG_VFP   = 2;

endpackage
